//--- common/correlator_macros.svh
/*
 * Size definitions for the cross-correlator.
 * Include this wherever a line, lag, tap or accumulator width is needed.
 */

`ifndef CORRELATOR_MACROS_SVH
`define CORRELATOR_MACROS_SVH

// Number of input lines sharing the common sample strobe.
`define CORR_NUM_LINES 4

// Width of one raw sample word.
`define CORR_SAMPLE_W 8

// Lags per baseline. Index 1 is the zero lag.
`define CORR_NUM_LAGS 3

// Delay line length, enough for base tap 3 plus one lag step.
`define CORR_TAP_DEPTH 5

// Signed width of each accumulator half.
`define CORR_RESOLUTION 24

`define CORR_NUM_BASELINES ((`CORR_NUM_LINES * (`CORR_NUM_LINES - 1)) / 2)

`endif

//--- common/corr_sample_pkg.sv
/*
 * Sample-side types: the dual-view sample word, the decoded line control,
 * the per-baseline settings and the tap pair used to read two delay lines.
 */

`include "correlator_macros.svh"

package corr_sample_pkg;

	localparam int NIBBLE_W = `CORR_SAMPLE_W / 2;
	localparam int TAP_SEL_W = $clog2(`CORR_TAP_DEPTH);

	typedef struct packed {
		logic signed [NIBBLE_W-1:0] re; // Upper nibble.
		logic signed [NIBBLE_W-1:0] im; // Lower nibble.
	} sample_cplx_t;

	// The same word is taken as one real value or as a small complex value.
	typedef union packed {
		logic signed [`CORR_SAMPLE_W-1:0] real_val;
		sample_cplx_t cplx;
	} sample_word_t;

	typedef struct packed {
		logic complex_fmt;
		logic diff_mode;
		logic enable;
		logic [1:0] base_tap;
	} line_ctrl_t;

	typedef struct packed {
		logic active;
		logic diff_mode;
		logic fmt_a;
		logic fmt_b;
		logic [1:0] tap_a;
		logic [1:0] tap_b;
	} baseline_cfg_t;

	typedef struct packed {
		logic [TAP_SEL_W-1:0] a;
		logic [TAP_SEL_W-1:0] b;
	} lag_tap_pair_t;

	// Baselines run (0,1), (0,2), (0,3), (1,2), (1,3), (2,3).
	function automatic int baseline_index(input int line_a, input int line_b);
		return line_a * (2 * `CORR_NUM_LINES - line_a - 1) / 2 + (line_b - line_a - 1);
	endfunction

endpackage

//--- common/corr_result_pkg.sv
/*
 * Result-side types: one complex accumulator, the lags of a baseline with
 * their overflow flags, and the full payload presented on dump.
 */

`include "correlator_macros.svh"

package corr_result_pkg;

	typedef struct packed {
		logic signed [`CORR_RESOLUTION-1:0] re;
		logic signed [`CORR_RESOLUTION-1:0] im;
	} complex_acc_t;

	typedef struct packed {
		complex_acc_t [`CORR_NUM_LAGS-1:0] lag;
		logic [`CORR_NUM_LAGS-1:0] overflow; // Sticky until clear or reset.
	} baseline_result_t;

	typedef baseline_result_t [`CORR_NUM_BASELINES-1:0] corr_payload_t;

endpackage

//--- delay_line/sample_delay_line.sv
/*
 * Shift register of past samples for one input line.
 * A new sample enters at tap 0 on each shift_en and every tap is readable.
 */

`timescale 1ns/1ps

`include "correlator_macros.svh"

module sample_delay_line
	import corr_sample_pkg::*;
(
	input logic pllclk,
	input logic reset,
	input logic shift_en,
	input sample_word_t sample_in,
	output sample_word_t [`CORR_TAP_DEPTH-1:0] taps
);

	sample_word_t [`CORR_TAP_DEPTH-1:0] line_q;

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			line_q <= '0;
		end else if (shift_en) begin
			line_q <= {line_q[`CORR_TAP_DEPTH-2:0], sample_in}; // Oldest sample drops out.
		end
	end

	assign taps = line_q;

endmodule

//--- design/line_control_decode.sv
/*
 * Registers the per-line control bytes and combines each pair of lines
 * into the settings of its baseline. Settings follow the bytes by one cycle.
 */

`timescale 1ns/1ps

`include "correlator_macros.svh"

module line_control_decode
	import corr_sample_pkg::*;
(
	input logic pllclk,
	input logic reset,
	input logic [`CORR_NUM_LINES-1:0][7:0] line_ctrl_in,
	output baseline_cfg_t [`CORR_NUM_BASELINES-1:0] baseline_cfg
);

	line_ctrl_t ctrl_q [`CORR_NUM_LINES];

	always_ff @(posedge pllclk) begin
		for (int n = 0; n < `CORR_NUM_LINES; n++) begin
			if (!reset) begin
				ctrl_q[n] <= '0;
			end else begin
				ctrl_q[n].enable <= line_ctrl_in[n][3];
				ctrl_q[n].diff_mode <= line_ctrl_in[n][4];
				ctrl_q[n].complex_fmt <= line_ctrl_in[n][5];
				ctrl_q[n].base_tap <= line_ctrl_in[n][1:0];
			end
		end
	end

	always_comb begin
		baseline_cfg = '0;
		for (int a = 0; a < `CORR_NUM_LINES - 1; a++) begin
			for (int b = a + 1; b < `CORR_NUM_LINES; b++) begin
				baseline_cfg[baseline_index(a, b)].active = ctrl_q[a].enable & ctrl_q[b].enable;
				// Difference mode needs both lines to ask for it.
				baseline_cfg[baseline_index(a, b)].diff_mode =
					ctrl_q[a].diff_mode & ctrl_q[b].diff_mode;
				baseline_cfg[baseline_index(a, b)].fmt_a = ctrl_q[a].complex_fmt;
				baseline_cfg[baseline_index(a, b)].fmt_b = ctrl_q[b].complex_fmt;
				baseline_cfg[baseline_index(a, b)].tap_a = ctrl_q[a].base_tap;
				baseline_cfg[baseline_index(a, b)].tap_b = ctrl_q[b].base_tap;
			end
		end
	end

endmodule

//--- correlator/baseline_accumulator.sv
/*
 * Two-stage accumulate path for every baseline and lag. Stage one forms the
 * conjugate product or the difference of the lag-shifted operands, stage two
 * adds it to the accumulator, holding the value and flagging on overflow.
 */

`timescale 1ns/1ps

`include "correlator_macros.svh"

module baseline_accumulator
	import corr_sample_pkg::*;
	import corr_result_pkg::*;
(
	input logic pllclk,
	input logic reset,
	input logic strobe,
	input logic clear,
	input baseline_cfg_t [`CORR_NUM_BASELINES-1:0] baseline_cfg,
	input sample_word_t [`CORR_NUM_LINES-1:0][`CORR_TAP_DEPTH-1:0] taps,
	output baseline_result_t [`CORR_NUM_BASELINES-1:0] results
);

	localparam int TERM_W = 2 * `CORR_SAMPLE_W + 1;
	localparam int RES = `CORR_RESOLUTION;

	logic strobe_d;
	complex_acc_t acc [`CORR_NUM_BASELINES][`CORR_NUM_LAGS];
	logic ovf [`CORR_NUM_BASELINES][`CORR_NUM_LAGS];

	function automatic logic signed [`CORR_SAMPLE_W-1:0] operand_re(input sample_word_t w,
			input logic cplx);
		if (cplx)
			return {{NIBBLE_W{w.cplx.re[NIBBLE_W-1]}}, w.cplx.re};
		return w.real_val;
	endfunction

	function automatic logic signed [`CORR_SAMPLE_W-1:0] operand_im(input sample_word_t w,
			input logic cplx);
		if (cplx)
			return {{NIBBLE_W{w.cplx.im[NIBBLE_W-1]}}, w.cplx.im};
		return '0; // A real sample has no imaginary part.
	endfunction

	// The delay lines hold the new sample one edge after the strobe.
	always_ff @(posedge pllclk) begin
		if (!reset)
			strobe_d <= 1'b0;
		else
			strobe_d <= strobe;
	end

	for (genvar la = 0; la < `CORR_NUM_LINES - 1; la++) begin : g_line_a
		for (genvar lb = la + 1; lb < `CORR_NUM_LINES; lb++) begin : g_line_b
			localparam int IDX = baseline_index(la, lb);
			baseline_cfg_t cfg;

			assign cfg = baseline_cfg[IDX];

			for (genvar l = 0; l < `CORR_NUM_LAGS; l++) begin : g_lag
				lag_tap_pair_t sel;
				logic signed [`CORR_SAMPLE_W-1:0] ar, ai, br, bi;
				logic signed [TERM_W-1:0] term_re, term_im;
				logic signed [TERM_W-1:0] term_re_q, term_im_q;
				logic term_valid;
				logic signed [RES:0] sum_re, sum_im;
				logic sum_ovf;

				// Lag 0 delays line a by one sample, lag 2 delays line b.
				assign sel.a = TAP_SEL_W'(cfg.tap_a) + TAP_SEL_W'(l == 0);
				assign sel.b = TAP_SEL_W'(cfg.tap_b) + TAP_SEL_W'(l == 2);

				assign ar = operand_re(taps[la][sel.a], cfg.fmt_a);
				assign ai = operand_im(taps[la][sel.a], cfg.fmt_a);
				assign br = operand_re(taps[lb][sel.b], cfg.fmt_b);
				assign bi = operand_im(taps[lb][sel.b], cfg.fmt_b);

				always_comb begin
					if (cfg.diff_mode) begin
						term_re = ar - br;
						term_im = ai - bi;
					end else begin
						term_re = ar * br + ai * bi; // a times conj(b).
						term_im = ai * br - ar * bi;
					end
				end

				always_ff @(posedge pllclk) begin
					term_re_q <= term_re;
					term_im_q <= term_im;
					if (!reset)
						term_valid <= 1'b0;
					else
						term_valid <= strobe_d & cfg.active & ~clear;
				end

				assign sum_re = acc[IDX][l].re + term_re_q;
				assign sum_im = acc[IDX][l].im + term_im_q;
				assign sum_ovf = (sum_re[RES] ^ sum_re[RES-1]) | (sum_im[RES] ^ sum_im[RES-1]);

				always_ff @(posedge pllclk) begin
					if (!reset || clear) begin
						acc[IDX][l] <= '0;
						ovf[IDX][l] <= 1'b0;
					end else if (term_valid && !ovf[IDX][l]) begin
						if (sum_ovf)
							ovf[IDX][l] <= 1'b1; // Value holds from here on.
						else
							acc[IDX][l] <= '{re: sum_re[RES-1:0], im: sum_im[RES-1:0]};
					end
				end
			end
		end
	end

	always_comb begin
		for (int b = 0; b < `CORR_NUM_BASELINES; b++) begin
			for (int l = 0; l < `CORR_NUM_LAGS; l++) begin
				results[b].lag[l] = acc[b][l];
				results[b].overflow[l] = ovf[b][l];
			end
		end
	end

endmodule

//--- design/payload_packer.sv
/*
 * Takes a snapshot of all accumulators and overflow flags on dump and holds
 * it until the next dump. payload_valid is high for the one cycle after.
 */

`timescale 1ns/1ps

`include "correlator_macros.svh"

module payload_packer
	import corr_result_pkg::*;
(
	input logic pllclk,
	input logic reset,
	input logic dump,
	input baseline_result_t [`CORR_NUM_BASELINES-1:0] results,
	output corr_payload_t payload,
	output logic payload_valid
);

	corr_payload_t snapshot_q;
	logic valid_q;

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			snapshot_q <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= dump; // One cycle per dump.
			if (dump) begin
				for (int b = 0; b < `CORR_NUM_BASELINES; b++)
					snapshot_q[b] <= results[b];
			end
		end
	end

	assign payload = snapshot_q;
	assign payload_valid = valid_q;

endmodule

//--- design/correlator_top.sv
/*
 * Four-line complex cross-correlator. Samples arrive on a common strobe,
 * six baselines by three lags are accumulated and a dump pulse snapshots them.
 */

`timescale 1ns/1ps

`include "correlator_macros.svh"

module correlator_top
	import corr_sample_pkg::*;
	import corr_result_pkg::*;
(
	input logic pllclk,
	input logic reset,
	input sample_word_t [`CORR_NUM_LINES-1:0] sample_in,
	input logic sample_strobe,
	input logic [`CORR_NUM_LINES-1:0][7:0] line_ctrl_in,
	input logic clear,
	input logic dump,
	output corr_payload_t payload,
	output logic payload_valid
);

	sample_word_t [`CORR_NUM_LINES-1:0][`CORR_TAP_DEPTH-1:0] line_taps;
	baseline_cfg_t [`CORR_NUM_BASELINES-1:0] baseline_cfg;
	baseline_result_t [`CORR_NUM_BASELINES-1:0] results;

	for (genvar n = 0; n < `CORR_NUM_LINES; n++) begin : g_line
		sample_delay_line u_delay (
			.pllclk (pllclk),
			.reset (reset),
			.shift_en (sample_strobe),
			.sample_in (sample_in[n]),
			.taps (line_taps[n])
		);
	end

	line_control_decode u_decode (
		.pllclk (pllclk),
		.reset (reset),
		.line_ctrl_in (line_ctrl_in),
		.baseline_cfg (baseline_cfg)
	);

	baseline_accumulator u_accumulate (
		.pllclk (pllclk),
		.reset (reset),
		.strobe (sample_strobe),
		.clear (clear),
		.baseline_cfg (baseline_cfg),
		.taps (line_taps),
		.results (results)
	);

	payload_packer u_pack (
		.pllclk (pllclk),
		.reset (reset),
		.dump (dump),
		.results (results),
		.payload (payload),
		.payload_valid (payload_valid)
	);

endmodule

//--- tests/correlator_tb.sv
/*
 * Self-checking testbench for the cross-correlator. Random samples run under
 * several line control settings while a model tracks delay lines and
 * accumulators. Every dump is compared with the model in the valid cycle.
 */

`timescale 1ns/1ps

`include "correlator_macros.svh"

module correlator_tb
	import corr_sample_pkg::*;
	import corr_result_pkg::*;
();

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 8;
	localparam int PHASE_CYCLES = 150;
	localparam int SAT_STROBES = 530; // 512 strobes of 16384 pass the 24-bit limit.
	localparam int HOLD_STROBES = 20;
	localparam int TEST_CYCLES = RESET_CYCLES + 3 * (PHASE_CYCLES + 40) + SAT_STROBES
		+ HOLD_STROBES + 120;
	localparam int MARGIN_CYCLES = 200;
	localparam int ACC_MAX = (1 << (`CORR_RESOLUTION - 1)) - 1;
	localparam int ACC_MIN = -(1 << (`CORR_RESOLUTION - 1));

	typedef struct packed {
		logic signed [31:0] re;
		logic signed [31:0] im;
	} term_t;

	logic pllclk;
	logic reset;
	sample_word_t [`CORR_NUM_LINES-1:0] sample_in;
	logic sample_strobe;
	logic [`CORR_NUM_LINES-1:0][7:0] line_ctrl_in;
	logic clear;
	logic dump;
	corr_payload_t payload;
	logic payload_valid;

	int seed;
	int dumps_sent = 0;
	int valid_cycles = 0;
	logic [7:0] model_line [`CORR_NUM_LINES][`CORR_TAP_DEPTH];
	int model_re [`CORR_NUM_BASELINES][`CORR_NUM_LAGS];
	int model_im [`CORR_NUM_BASELINES][`CORR_NUM_LAGS];
	logic model_ovf [`CORR_NUM_BASELINES][`CORR_NUM_LAGS];
	int exp_re [`CORR_NUM_BASELINES][`CORR_NUM_LAGS];
	int exp_im [`CORR_NUM_BASELINES][`CORR_NUM_LAGS];
	logic exp_ovf [`CORR_NUM_BASELINES][`CORR_NUM_LAGS];

	correlator_top uut (
		.pllclk (pllclk),
		.reset (reset),
		.sample_in (sample_in),
		.sample_strobe (sample_strobe),
		.line_ctrl_in (line_ctrl_in),
		.clear (clear),
		.dump (dump),
		.payload (payload),
		.payload_valid (payload_valid)
	);

	initial begin
		pllclk = 1'b0;
		forever #(CLK_PERIOD / 2) pllclk = ~pllclk;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic check_value(input string name, input logic signed [63:0] got,
			input logic signed [63:0] expected);
		if (got !== expected) begin
			$display("FAILED time=%0t signal=%s got=%0d expected=%0d", $time, name, got,
				expected);
			abort_run("Value mismatch.");
		end
	endtask

	function automatic logic [7:0] ctrl_byte(input logic en, input logic diff, input logic cplx,
			input logic [1:0] tap);
		return {2'b00, cplx, diff, en, 1'b0, tap};
	endfunction

	// Contribution of one strobe, a times conj(b) or a minus b.
	function automatic term_t expected_term(input logic [7:0] wa, input logic fa,
			input logic [7:0] wb, input logic fb, input logic diff);
		int ar;
		int ai;
		int br;
		int bi;
		term_t t;
		ar = fa ? int'($signed(wa[7:4])) : int'($signed(wa));
		ai = fa ? int'($signed(wa[3:0])) : 0;
		br = fb ? int'($signed(wb[7:4])) : int'($signed(wb));
		bi = fb ? int'($signed(wb[3:0])) : 0;
		if (diff) begin
			t.re = ar - br;
			t.im = ai - bi;
		end else begin
			t.re = ar * br + ai * bi;
			t.im = ai * br - ar * bi;
		end
		return t;
	endfunction

	task automatic clear_model_acc();
		for (int b = 0; b < `CORR_NUM_BASELINES; b++) begin
			for (int l = 0; l < `CORR_NUM_LAGS; l++) begin
				model_re[b][l] = 0;
				model_im[b][l] = 0;
				model_ovf[b][l] = 1'b0;
			end
		end
	endtask

	// Shifts the model lines and accumulates every active baseline and lag.
	task automatic model_strobe();
		int idx;
		int ta;
		int tb;
		int sum_re;
		int sum_im;
		term_t t;
		logic [7:0] ca;
		logic [7:0] cb;
		for (int n = 0; n < `CORR_NUM_LINES; n++) begin
			for (int k = `CORR_TAP_DEPTH - 1; k > 0; k--)
				model_line[n][k] = model_line[n][k-1];
			model_line[n][0] = sample_in[n];
		end
		idx = 0;
		for (int a = 0; a < `CORR_NUM_LINES - 1; a++) begin
			for (int b = a + 1; b < `CORR_NUM_LINES; b++) begin
				ca = line_ctrl_in[a];
				cb = line_ctrl_in[b];
				for (int l = 0; l < `CORR_NUM_LAGS && ca[3] && cb[3]; l++) begin
					ta = ca[1:0] + (l == 0);
					tb = cb[1:0] + (l == 2);
					t = expected_term(model_line[a][ta], ca[5], model_line[b][tb], cb[5],
						ca[4] && cb[4]);
					sum_re = model_re[idx][l] + t.re;
					sum_im = model_im[idx][l] + t.im;
					if (model_ovf[idx][l]) begin
						// Held since the overflow.
					end else if (sum_re > ACC_MAX || sum_re < ACC_MIN
							|| sum_im > ACC_MAX || sum_im < ACC_MIN) begin
						model_ovf[idx][l] = 1'b1;
					end else begin
						model_re[idx][l] = sum_re;
						model_im[idx][l] = sum_im;
					end
				end
				idx++;
			end
		end
	endtask

	task automatic drive_idle(input int cycles);
		repeat (cycles) begin
			@(posedge pllclk);
			#1;
			sample_strobe = 1'b0;
			clear = 1'b0;
			dump = 1'b0;
		end
	endtask

	task automatic drive_strobe(input logic [`CORR_NUM_LINES-1:0][7:0] samples);
		@(posedge pllclk);
		#1;
		sample_in = samples;
		sample_strobe = 1'b1;
		clear = 1'b0;
		dump = 1'b0;
		model_strobe();
	endtask

	task automatic run_random_strobes(input int cycles);
		logic [`CORR_NUM_LINES-1:0][7:0] samples;
		for (int i = 0; i < cycles; i++) begin
			samples = $random(seed);
			if (($random(seed) & 3) != 0)
				drive_strobe(samples);
			else
				drive_idle(1);
		end
	endtask

	task automatic set_control(input logic [7:0] c0, input logic [7:0] c1,
			input logic [7:0] c2, input logic [7:0] c3);
		drive_idle(1);
		line_ctrl_in[0] = c0;
		line_ctrl_in[1] = c1;
		line_ctrl_in[2] = c2;
		line_ctrl_in[3] = c3;
		drive_idle(2);
	endtask

	task automatic pulse_clear();
		drive_idle(3); // Let strobes in flight land first.
		clear = 1'b1;
		clear_model_acc();
		drive_idle(1);
	endtask

	task automatic dump_and_check();
		int waited;
		drive_idle(3);
		exp_re = model_re;
		exp_im = model_im;
		exp_ovf = model_ovf;
		dump = 1'b1;
		dumps_sent++;
		drive_idle(1);
		waited = 0;
		while (valid_cycles < dumps_sent && waited < 8) begin
			@(posedge pllclk);
			waited++;
		end
		if (valid_cycles < dumps_sent)
			abort_run("payload_valid did not rise after a dump.");
		drive_idle(2);
		check_value("payload_valid pulse count", valid_cycles, dumps_sent);
	endtask

	task automatic compare_payload();
		for (int b = 0; b < `CORR_NUM_BASELINES; b++) begin
			for (int l = 0; l < `CORR_NUM_LAGS; l++) begin
				check_value($sformatf("payload[%0d].lag[%0d].re", b, l),
					$signed(payload[b].lag[l].re), exp_re[b][l]);
				check_value($sformatf("payload[%0d].lag[%0d].im", b, l),
					$signed(payload[b].lag[l].im), exp_im[b][l]);
				check_value($sformatf("payload[%0d].overflow[%0d]", b, l),
					payload[b].overflow[l], exp_ovf[b][l]);
			end
		end
	endtask

	// Payload only moves on a rising edge, so the falling edge is a safe point.
	always @(negedge pllclk) begin
		if (payload_valid) begin
			valid_cycles++;
			compare_payload();
		end
	end

	initial begin
		#(TEST_CYCLES * CLK_PERIOD + MARGIN_CYCLES * CLK_PERIOD);
		abort_run("Timeout: the test sequence did not finish in time.");
	end

	initial begin
		int held_re [`CORR_NUM_LAGS];
		int held_im [`CORR_NUM_LAGS];
		logic [`CORR_NUM_LINES-1:0][7:0] samples;
		seed = 32'h4508063c;
		reset = 1'b0;
		sample_in = '0;
		sample_strobe = 1'b0;
		line_ctrl_in = '0;
		clear = 1'b0;
		dump = 1'b0;
		for (int n = 0; n < `CORR_NUM_LINES; n++)
			for (int k = 0; k < `CORR_TAP_DEPTH; k++)
				model_line[n][k] = 8'h00;
		clear_model_acc();
		repeat (RESET_CYCLES) @(posedge pllclk);
		#1;
		reset = 1'b1;

		drive_idle(5);
		check_value("payload_valid", payload_valid, 0);
		dump_and_check();

		set_control(ctrl_byte(1, 0, 0, 0), ctrl_byte(1, 0, 0, 0), ctrl_byte(1, 0, 0, 0),
			ctrl_byte(1, 0, 0, 0));
		run_random_strobes(PHASE_CYCLES);
		dump_and_check();

		// Line 3 is off, (0,1) runs in difference mode, the rest multiply.
		set_control(ctrl_byte(1, 1, 1, 0), ctrl_byte(1, 1, 0, 0), ctrl_byte(1, 0, 1, 0),
			ctrl_byte(0, 1, 1, 0));
		pulse_clear();
		run_random_strobes(PHASE_CYCLES);
		dump_and_check();
		for (int b = 2; b < `CORR_NUM_BASELINES; b++)
			for (int l = 0; l < `CORR_NUM_LAGS && b != 3; l++)
				check_value($sformatf("payload[%0d].lag[%0d]", b, l), payload[b].lag[l], 0);

		set_control(ctrl_byte(1, 0, 0, 3), ctrl_byte(1, 0, 1, 1), ctrl_byte(1, 1, 0, 2),
			ctrl_byte(1, 1, 1, 0));
		run_random_strobes(PHASE_CYCLES);
		dump_and_check();

		set_control(ctrl_byte(1, 0, 0, 0), ctrl_byte(1, 0, 0, 0), ctrl_byte(1, 0, 0, 0),
			ctrl_byte(1, 0, 0, 0));
		pulse_clear();
		for (int i = 0; i < SAT_STROBES; i++) begin
			samples = $random(seed);
			samples[0] = 8'h80;
			samples[1] = 8'h80;
			drive_strobe(samples);
		end
		dump_and_check();
		check_value("payload[0].overflow", payload[0].overflow, 3'b111);
		check_value("payload[5].overflow", payload[5].overflow, 0);
		for (int l = 0; l < `CORR_NUM_LAGS; l++) begin
			held_re[l] = exp_re[0][l];
			held_im[l] = exp_im[0][l];
		end
		for (int i = 0; i < HOLD_STROBES; i++) begin
			samples = $random(seed);
			samples[0] = 8'h80;
			samples[1] = 8'h80;
			drive_strobe(samples);
		end
		dump_and_check();
		for (int l = 0; l < `CORR_NUM_LAGS; l++) begin
			check_value($sformatf("payload[0].lag[%0d].re", l),
				$signed(payload[0].lag[l].re), held_re[l]);
			check_value($sformatf("payload[0].lag[%0d].im", l),
				$signed(payload[0].lag[l].im), held_im[l]);
		end

		pulse_clear();
		dump_and_check();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- build.f
+incdir+common
common/corr_sample_pkg.sv
common/corr_result_pkg.sv
delay_line/sample_delay_line.sv
design/line_control_decode.sv
correlator/baseline_accumulator.sv
design/payload_packer.sv
design/correlator_top.sv
tests/correlator_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the correlator testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module correlator_tb -f build.f \
	-o correlator_sim

# The simulator status is not used here; the log decides.
./obj_dir/correlator_sim | tee sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
	echo "Simulation passed."
else
	echo "Simulation failed, see sim.log."
	exit 1
fi
